//--- source/colmix_pkg.sv
// Shared types for the colour mixer; default raster is tiny and only suits simulation
package colmix_pkg;

    // Default raster sizes in pixels and lines
    localparam int H_TOTAL_DEF   = 64;
    localparam int H_ACTIVE_DEF  = 48;
    localparam int V_TOTAL_DEF   = 16;
    localparam int V_ACTIVE_DEF  = 12;

    // Pixels between layer sampling and the video output
    localparam int BLANK_DLY_DEF = 3;

    // One layer colour request, 7 bits
    typedef struct packed {
        logic [1:0] bank;
        // Only honoured on layer 2
        logic       prio;
        // Zero is transparent
        logic [3:0] index;
    } layer_pxl_t;

    // CPU side of the palette
    typedef struct packed {
        logic       cs;
        logic       rnw;
        logic       cen;
        logic [7:0] addr;
        logic [7:0] din;
    } cpu_bus_t;

    // Active-low blanking pair
    // High while the beam is inside the visible area
    typedef struct packed {
        logic lhbl;
        logic lvbl;
    } blank_t;

    // 15-bit colour, blue on top
    typedef struct packed {
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } rgb_t;

    // Palette byte phase, also the address LSB
    // HI sits at the even address
    typedef enum logic {
        HALF_HI = 1'b0,
        HALF_LO = 1'b1
    } pal_half_e;

endpackage

//--- source/video_timing.sv
// Single clock; pxl_cen is clk/2 and the blank pair lags the counters by one pixel enable
`timescale 1ns/1ps

module video_timing #(
    parameter int H_TOTAL  = colmix_pkg::H_TOTAL_DEF,
    parameter int H_ACTIVE = colmix_pkg::H_ACTIVE_DEF,
    parameter int V_TOTAL  = colmix_pkg::V_TOTAL_DEF,
    parameter int V_ACTIVE = colmix_pkg::V_ACTIVE_DEF
) (
    input  logic               clk,
    input  logic               rst,
    output logic               pxl_cen,
    output colmix_pkg::blank_t blank
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    // Dot and line counters
    logic [HW-1:0] hcnt;
    logic [VW-1:0] vcnt;
    logic          h_wrap;
    logic          v_wrap;

    // Last pixel of a line, last line of a frame
    assign h_wrap = (hcnt == HW'(H_TOTAL - 1));
    assign v_wrap = (vcnt == VW'(V_TOTAL - 1));

    // Divide by two
    // Low in reset, so the first pulse lands on the second clock
    always_ff @(posedge clk) begin
        if (rst) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // Counters only move on pixel enables
    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (h_wrap) begin
                hcnt <= '0;
                // Line counter steps at the end of each line
                if (v_wrap) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 1'b1;
                end
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    // Blanking for the pixel just counted
    // Registered alongside the count step, so it is one pixel behind hcnt
    // Starts blanked out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            blank <= '0;
        end else if (pxl_cen) begin
            blank.lhbl <= (hcnt < HW'(H_ACTIVE));
            blank.lvbl <= (vcnt < VW'(V_ACTIVE));
        end
    end

endmodule

//--- source/palette_ram.sv
// 256-byte palette with no reset; contents are undefined until the CPU writes them
`timescale 1ns/1ps

module palette_ram (
    input  logic                 clk,
    input  colmix_pkg::cpu_bus_t cpu,
    output logic [7:0]           pal_dout,
    input  logic [7:0]           vid_addr,
    output logic [7:0]           vid_q
);

    // Two bytes per colour code
    logic [7:0] mem [256];
    logic       cpu_we;

    // Plain strobes, no handshake
    // Chip select, CPU clock enable and a write cycle together
    assign cpu_we = cpu.cs & cpu.cen & ~cpu.rnw;

    // CPU port
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu.addr] <= cpu.din;
        end
    end

    // CPU read back
    // Runs every clock whatever cs is
    // Old data comes out on a write to the same address
    always_ff @(posedge clk) begin
        pal_dout <= mem[cpu.addr];
    end

    // Video port
    // Read only, one clock latency
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr];
    end

endmodule

//--- source/colour_mixer.sv
// Needs pxl_cen strictly every second clock; rgb holds the colour of the previous pixel
`timescale 1ns/1ps

module colour_mixer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  colmix_pkg::layer_pxl_t gfx1,
    input  colmix_pkg::layer_pxl_t gfx2,
    output logic [7:0]             vid_addr,
    input  logic [7:0]             vid_q,
    output colmix_pkg::rgb_t       rgb
);

    logic                   use_gfx2;
    colmix_pkg::layer_pxl_t sel_code;
    colmix_pkg::layer_pxl_t code_q;
    colmix_pkg::layer_pxl_t addr_code;
    colmix_pkg::pal_half_e  phase;
    logic [6:0]             hi_hold;

    // Layer 2 wins when layer 1 is transparent
    // or when layer 2 asks for priority
    assign use_gfx2 = (gfx1.index == 4'd0) || gfx2.prio;
    assign sel_code = use_gfx2 ? gfx2 : gfx1;

    // HI phase lines up with pxl_cen
    // The RAM samples the live choice on that edge, the latched code after it
    assign addr_code = (phase == colmix_pkg::HALF_HI) ? sel_code : code_q;
    assign vid_addr  = {addr_code, phase};

    // Byte phase
    // HI on the pxl_cen clock, LO on the clock between
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= colmix_pkg::HALF_LO;
        end else if (pxl_cen) begin
            phase <= colmix_pkg::HALF_LO;
        end else begin
            phase <= colmix_pkg::HALF_HI;
        end
    end

    // Chosen code, kept for the LO fetch
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            code_q <= sel_code;
        end
    end

    // HI byte is on vid_q during the LO phase
    // Top bit of HI is unused
    always_ff @(posedge clk) begin
        if (phase == colmix_pkg::HALF_LO) begin
            hi_hold <= vid_q[6:0];
        end
    end

    // Assemble on the next pixel enable
    // LO byte is on vid_q by then
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            rgb.blue  <= hi_hold[6:2];
            // Green is split across both bytes
            rgb.green <= {hi_hold[1:0], vid_q[7:5]};
            rgb.red   <= vid_q[4:0];
        end
    end

endmodule

//--- source/blank_delay.sv
// BLANK_DLY must be 2 or more; colour is forced to black while either delayed level is low
`timescale 1ns/1ps

module blank_delay #(
    parameter int BLANK_DLY = colmix_pkg::BLANK_DLY_DEF
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               pxl_cen,
    input  colmix_pkg::blank_t blank,
    input  colmix_pkg::rgb_t   rgb_in,
    output colmix_pkg::blank_t blank_dly,
    output colmix_pkg::rgb_t   rgb
);

    // Blanking chain is one stage longer
    // The colour enters it a pixel later than the blanking
    colmix_pkg::blank_t blank_pipe [BLANK_DLY];
    colmix_pkg::rgb_t   rgb_pipe   [BLANK_DLY-1];
    colmix_pkg::rgb_t   rgb_src    [BLANK_DLY-1];
    logic               pipe_blanked;

    // Stage inputs, first one from the mixer
    always_comb begin
        rgb_src[0] = rgb_in;
        for (int i = 1; i < BLANK_DLY - 1; i++) begin
            rgb_src[i] = rgb_pipe[i-1];
        end
    end

    // Blanking of the pixel entering the last colour stage
    assign pipe_blanked = ~blank_pipe[BLANK_DLY-2].lhbl | ~blank_pipe[BLANK_DLY-2].lvbl;

    always_ff @(posedge clk) begin
        if (rst) begin
            blank_pipe            <= '{default: '0};
            rgb_pipe[BLANK_DLY-2] <= '0;
        end else if (pxl_cen) begin
            blank_pipe[0] <= blank;
            for (int i = 1; i < BLANK_DLY; i++) begin
                blank_pipe[i] <= blank_pipe[i-1];
            end
            // Plain colour stages
            for (int i = 0; i < BLANK_DLY - 2; i++) begin
                rgb_pipe[i] <= rgb_src[i];
            end
            // Final stage blacks out blanked pixels
            rgb_pipe[BLANK_DLY-2] <= pipe_blanked ? '0 : rgb_src[BLANK_DLY-2];
        end
    end

    assign blank_dly = blank_pipe[BLANK_DLY-1];
    assign rgb       = rgb_pipe[BLANK_DLY-2];

endmodule

//--- source/video_colmix_top.sv
// One clock for CPU and video; outputs show the pixel sampled BLANK_DLY pixel enables earlier
`timescale 1ns/1ps

module video_colmix_top #(
    parameter int H_TOTAL   = colmix_pkg::H_TOTAL_DEF,
    parameter int H_ACTIVE  = colmix_pkg::H_ACTIVE_DEF,
    parameter int V_TOTAL   = colmix_pkg::V_TOTAL_DEF,
    parameter int V_ACTIVE  = colmix_pkg::V_ACTIVE_DEF,
    parameter int BLANK_DLY = colmix_pkg::BLANK_DLY_DEF
) (
    input  logic                   clk,
    input  logic                   rst,
    input  colmix_pkg::cpu_bus_t   cpu,
    input  colmix_pkg::layer_pxl_t gfx1,
    input  colmix_pkg::layer_pxl_t gfx2,
    output logic [7:0]             pal_dout,
    output logic                   pxl_cen,
    output colmix_pkg::blank_t     blank_dly,
    output colmix_pkg::rgb_t       rgb
);

    colmix_pkg::blank_t blank;
    colmix_pkg::rgb_t   mix_rgb;
    logic [7:0]         vid_addr;
    logic [7:0]         vid_q;

    // Raster timing
    video_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE)
    ) timing_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .blank   (blank)
    );

    // Palette, CPU port and video port
    palette_ram palette_i (
        .clk      (clk),
        .cpu      (cpu),
        .pal_dout (pal_dout),
        .vid_addr (vid_addr),
        .vid_q    (vid_q)
    );

    // Priority and two-byte fetch
    colour_mixer mixer_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .gfx1     (gfx1),
        .gfx2     (gfx2),
        .vid_addr (vid_addr),
        .vid_q    (vid_q),
        .rgb      (mix_rgb)
    );

    // Align blanking with colour and black out
    blank_delay #(
        .BLANK_DLY (BLANK_DLY)
    ) blank_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .blank     (blank),
        .rgb_in    (mix_rgb),
        .blank_dly (blank_dly),
        .rgb       (rgb)
    );

endmodule

//--- testbench/colmix_tb.sv
// Single clock, default tiny raster; palette fully loaded by the CPU port before colours are checked
`timescale 1ns/1ps

module colmix_tb;

    localparam int H_TOTAL   = colmix_pkg::H_TOTAL_DEF;
    localparam int H_ACTIVE  = colmix_pkg::H_ACTIVE_DEF;
    localparam int V_TOTAL   = colmix_pkg::V_TOTAL_DEF;
    localparam int V_ACTIVE  = colmix_pkg::V_ACTIVE_DEF;
    localparam int BLANK_DLY = colmix_pkg::BLANK_DLY_DEF;

    // Four frames of two clocks per pixel, plus palette loading
    localparam int LOAD_CLKS    = 600;
    localparam int TIMEOUT_CLKS = H_TOTAL * V_TOTAL * 2 * 4 + LOAD_CLKS;

    // One sampled pixel waiting for its output
    typedef struct packed {
        colmix_pkg::layer_pxl_t g1;
        colmix_pkg::layer_pxl_t g2;
        colmix_pkg::blank_t     blank;
        logic                   valid;
    } pix_entry_t;

    logic                   clk;
    logic                   rst;
    colmix_pkg::cpu_bus_t   cpu;
    colmix_pkg::layer_pxl_t gfx1;
    colmix_pkg::layer_pxl_t gfx2;
    logic [7:0]             pal_dout;
    logic                   pxl_cen;
    colmix_pkg::blank_t     blank_dly;
    colmix_pkg::rgb_t       rgb;

    // Shadow palette and bookkeeping
    logic [7:0] shadow [256];
    logic [31:0] rng_state;
    pix_entry_t pix_q [$];
    int         hpos;
    int         vpos;
    logic       cen_exp;
    logic       video_check;
    int         err_rgb;
    int         err_blank;
    int         err_byte;
    int         err_cen;
    int         cycles;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    video_colmix_top #(
        .H_TOTAL   (H_TOTAL),
        .H_ACTIVE  (H_ACTIVE),
        .V_TOTAL   (V_TOTAL),
        .V_ACTIVE  (V_ACTIVE),
        .BLANK_DLY (BLANK_DLY)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .cpu       (cpu),
        .gfx1      (gfx1),
        .gfx2      (gfx2),
        .pal_dout  (pal_dout),
        .pxl_cen   (pxl_cen),
        .blank_dly (blank_dly),
        .rgb       (rgb)
    );

    // xorshift32
    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Priority rule, then the two palette bytes of the chosen code
    function colmix_pkg::rgb_t expected_rgb(colmix_pkg::layer_pxl_t g1,
                                            colmix_pkg::layer_pxl_t g2);
        colmix_pkg::layer_pxl_t code;
        logic [7:0]             hi;
        logic [7:0]             lo;
        colmix_pkg::rgb_t       res;
        code = ((g1.index == 4'd0) || g2.prio) ? g2 : g1;
        hi = shadow[{code, colmix_pkg::HALF_HI}];
        lo = shadow[{code, colmix_pkg::HALF_LO}];
        res.blue  = hi[6:2];
        res.green = {hi[1:0], lo[7:5]};
        res.red   = lo[4:0];
        return res;
    endfunction

    task check_rgb(colmix_pkg::rgb_t got, colmix_pkg::rgb_t exp, string what);
        if (got !== exp) begin
            err_rgb++;
            $display("[FAIL] %0d ns: %s rgb got %h expected %h", $time, what, got, exp);
        end
    endtask

    task check_blank(colmix_pkg::blank_t got, colmix_pkg::blank_t exp, string what);
        if (got !== exp) begin
            err_blank++;
            $display("[FAIL] %0d ns: %s blank got %b expected %b", $time, what, got, exp);
        end
    endtask

    task check_byte(logic [7:0] got, logic [7:0] exp, string what);
        if (got !== exp) begin
            err_byte++;
            $display("[FAIL] %0d ns: %s byte got %h expected %h", $time, what, got, exp);
        end
    endtask

    task check_cen(logic got, logic exp, string what);
        if (got !== exp) begin
            err_cen++;
            $display("[FAIL] %0d ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Pixels already sampled read stale palette data after a write
    task flush_in_flight();
        foreach (pix_q[i]) begin
            pix_q[i].valid = 1'b0;
        end
    endtask

    // Single-clock palette write, bus idles afterwards
    task palette_write(logic [7:0] addr, logic [7:0] data);
        @(posedge clk);
        cpu <= '{cs: 1'b1, rnw: 1'b0, cen: 1'b1, addr: addr, din: data};
        @(posedge clk);
        cpu <= '{cs: 1'b0, rnw: 1'b1, cen: 1'b1, addr: addr, din: 8'h00};
        // RAM holds the new byte from here on
        @(negedge clk);
        shadow[addr] = data;
        flush_in_flight();
    endtask

    // New layer codes on each pixel enable
    // mode 0 steers random codes, mode 1 holds gfx1 at fixed_code
    task drive_pixels(int count, int mode, colmix_pkg::layer_pxl_t fixed_code);
        int                     n;
        logic [31:0]            r;
        colmix_pkg::layer_pxl_t g1;
        colmix_pkg::layer_pxl_t g2;
        n = 0;
        while (n < count) begin
            @(posedge clk);
            if (pxl_cen) begin
                r  = next_random();
                g1 = r[6:0];
                g2 = r[13:7];
                if (mode == 1) begin
                    g1 = fixed_code;
                    g2.prio = 1'b0;
                end else if (r[17:16] == 2'd0) begin
                    // gfx1 transparent
                    g1.index = 4'd0;
                end else if (r[17:16] == 2'd1) begin
                    g2.prio = 1'b1;
                end else begin
                    // gfx1 wins
                    g2.prio = 1'b0;
                    if (g1.index == 4'd0) begin
                        g1.index = 4'd1;
                    end
                end
                gfx1 <= g1;
                gfx2 <= g2;
                n++;
            end
        end
    endtask

    // Pixel enable every second clock, first one on the second clock out of reset
    always @(posedge clk) begin
        if (rst) begin
            cen_exp = 1'b0;
        end else begin
            check_cen(pxl_cen, cen_exp, "pixel enable");
            cen_exp = ~cen_exp;
        end
    end

    // Sample on pixel enables, compare on the clock between
    always @(posedge clk) begin
        pix_entry_t entry;
        if (rst) begin
            hpos = 0;
            vpos = 0;
            pix_q.delete();
        end else if (pxl_cen) begin
            entry.g1         = gfx1;
            entry.g2         = gfx2;
            entry.blank.lhbl = (hpos < H_ACTIVE);
            entry.blank.lvbl = (vpos < V_ACTIVE);
            entry.valid      = 1'b1;
            pix_q.push_back(entry);
            // Own raster counters
            if (hpos == H_TOTAL - 1) begin
                hpos = 0;
                vpos = (vpos == V_TOTAL - 1) ? 0 : vpos + 1;
            end else begin
                hpos++;
            end
        end else if (pix_q.size() > BLANK_DLY) begin
            entry = pix_q.pop_front();
            check_blank(blank_dly, entry.blank, "delayed");
            if (!(entry.blank.lhbl && entry.blank.lvbl)) begin
                check_rgb(rgb, '0, "blanked pixel");
            end else if (video_check && entry.valid) begin
                check_rgb(rgb, expected_rgb(entry.g1, entry.g2), "active pixel");
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CLKS) begin
            $display("timeout: run did not finish within %0d clocks", TIMEOUT_CLKS);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        rng_state   = 32'd1372;
        cpu         = '{cs: 1'b0, rnw: 1'b1, cen: 1'b0, addr: 8'h00, din: 8'h00};
        gfx1        = '0;
        gfx2        = '0;
        rst         = 1'b1;
        video_check = 1'b0;
        err_rgb     = 0;
        err_blank   = 0;
        err_byte    = 0;
        err_cen     = 0;
        cycles      = 0;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Outputs still black and blanked before the first pixel
        @(posedge clk);
        @(negedge clk);
        check_blank(blank_dly, '0, "after reset");
        check_rgb(rgb, '0, "after reset");

        // Fill all 256 bytes back to back
        for (int a = 0; a < 256; a++) begin
            r = next_random();
            @(posedge clk);
            cpu <= '{cs: 1'b1, rnw: 1'b0, cen: 1'b1, addr: 8'(a), din: r[7:0]};
            shadow[a] = r[7:0];
        end

        // Strobes that must not write
        @(posedge clk);
        cpu <= '{cs: 1'b0, rnw: 1'b0, cen: 1'b1, addr: 8'h10, din: ~shadow[8'h10]};
        @(posedge clk);
        cpu <= '{cs: 1'b1, rnw: 1'b0, cen: 1'b0, addr: 8'h11, din: ~shadow[8'h11]};

        // Read back, one address per clock
        for (int i = 0; i <= 256; i++) begin
            @(posedge clk);
            cpu <= '{cs: 1'b1, rnw: 1'b1, cen: 1'b1, addr: 8'(i), din: 8'h00};
            @(negedge clk);
            if (i > 0) begin
                check_byte(pal_dout, shadow[i-1], "read back");
            end
        end

        video_check = 1'b1;
        flush_in_flight();

        // Distinct HI and LO bytes for code 35h
        palette_write({7'h35, colmix_pkg::HALF_HI}, 8'h59);
        palette_write({7'h35, colmix_pkg::HALF_LO}, 8'hCD);
        @(posedge clk);
        gfx1 <= 7'h35;
        gfx2 <= '0;
        repeat (2 * (BLANK_DLY + 2)) @(posedge clk);
        @(negedge clk);
        while (blank_dly !== 2'b11) begin
            @(negedge clk);
        end
        check_rgb(rgb, {5'b10110, 5'b01110, 5'b01101}, "byte assembly");

        // One frame of steered random codes
        drive_pixels(H_TOTAL * V_TOTAL, 0, '0);

        // Mid-frame palette change, then pixels that use the code
        palette_write({7'h22, colmix_pkg::HALF_LO}, ~shadow[{7'h22, colmix_pkg::HALF_LO}]);
        drive_pixels(300, 1, 7'h22);
        drive_pixels(H_TOTAL * V_TOTAL / 2, 0, '0);

        // Let the last pixels drain
        repeat (2 * (BLANK_DLY + 3)) @(posedge clk);

        $display("errors: rgb %0d, blank %0d, byte %0d, cen %0d",
                 err_rgb, err_blank, err_byte, err_cen);
        if (err_rgb + err_blank + err_byte + err_cen == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- files.f
source/colmix_pkg.sv
source/video_timing.sv
source/palette_ram.sv
source/colour_mixer.sv
source/blank_delay.sv
source/video_colmix_top.sv
testbench/colmix_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the colour mixer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f files.f \
    --top-module colmix_tb \
    -o colmix_sim

sim_out=$(./obj_dir/colmix_sim)
echo "$sim_out"

# The testbench prints the pass message only when every check held
if grep -qx "sim passed" <<< "$sim_out"; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi
